/* Bender.yml */
package:
  name: tetris_core

sources:
  - design/tetris_pkg.sv
  - design/board_ram.sv
  - design/board_arbiter.sv
  - design/lock_unit.sv
  - design/collision_check.sv
  - design/piece_ctl.sv
  - design/tetris_core.sv
  - target: simulation
    files:
      - dv/tetris_core_tb.sv

/* design/board_arbiter.sv */
`timescale 1ns/100ps

module board_arbiter import tetris_pkg::*; (
    input  board_req_t lock_req,
    input  board_req_t chk_req,
    input  board_req_t disp_req,
    output logic       lock_gnt,
    output logic       chk_gnt,
    output logic       disp_gnt,
    output logic       chk_rvalid,
    output logic       disp_rvalid,
    output board_req_t ram_req,
    input  logic       pclk,
    input  logic       rst
);

    typedef enum logic [1:0] {own_none, own_chk, own_disp} owner_e;

    owner_e owner;  // who gets the data on this edge

    // a reader still waiting for its row is skipped for that cycle
    assign lock_gnt = lock_req.req;
    assign chk_gnt  = chk_req.req && !lock_gnt && owner != own_chk;
    assign disp_gnt = disp_req.req && !lock_gnt && !chk_gnt && owner != own_disp;

    always_comb begin
        if (lock_gnt)      ram_req = lock_req;
        else if (chk_gnt)  ram_req = chk_req;
        else if (disp_gnt) ram_req = disp_req;
        else               ram_req = '0;
    end

    always_ff @(posedge pclk) begin
        if (rst) owner <= own_none;
        else if (chk_gnt) owner <= own_chk;
        else if (disp_gnt) owner <= own_disp;
        else owner <= own_none;
    end

    assign chk_rvalid  = (owner == own_chk);
    assign disp_rvalid = (owner == own_disp);

    a_one_grant: assert property (@(posedge pclk) disable iff (rst)
        $onehot0({lock_gnt, chk_gnt, disp_gnt}));

endmodule

/* design/board_ram.sv */
`timescale 1ns/100ps

module board_ram import tetris_pkg::*; (
    input  logic       pclk,
    input  logic       rst,
    input  board_req_t ram_req,
    output row_bits_t  rdata
);

    row_bits_t rows [board_rows];

    always_ff @(posedge pclk) begin
        if (rst) begin
            for (int r = 0; r < board_rows; r++) rows[r] <= '0;
        end else if (ram_req.req && ram_req.we && ram_req.row < row_t'(board_rows)
                     && ram_req.col < col_t'(board_cols)) begin
            rows[ram_req.row][ram_req.col] <= 1'b1;  // off-board cells dropped
        end
    end

    always_ff @(posedge pclk) begin
        if (ram_req.req && !ram_req.we) begin
            rdata <= (ram_req.row < row_t'(board_rows)) ? rows[ram_req.row] : '0;
        end
    end

endmodule

/* design/collision_check.sv */
`timescale 1ns/100ps

module collision_check import tetris_pkg::*; (
    input  logic         pclk,
    input  logic         rst,
    input  logic         check_start,
    input  piece_cells_t cells,
    output logic         check_done,
    output logic         hit,
    output board_req_t   breq,
    input  logic         bgnt,
    input  logic         rvalid,
    input  row_bits_t    rdata
);

    piece_cells_t cl;
    logic         busy;
    logic         pend;      // read granted, data not back yet
    logic         hit_acc;
    logic [1:0]   idx;
    cell_t        cur;
    logic         below;
    logic         step;
    logic         cell_hit;

    assign cur      = cl[idx];
    assign below    = cur.row >= row_t'(board_rows);  // past the floor, no read
    assign step     = busy && (below || rvalid);
    assign cell_hit = below || rdata[cur.col];

    assign breq = '{row: cur.row, col: cur.col, we: 1'b0, req: busy && !pend && !below};

    always_ff @(posedge pclk) begin
        if (rst) begin
            busy       <= 1'b0;
            pend       <= 1'b0;
            hit_acc    <= 1'b0;
            idx        <= 2'd0;
            check_done <= 1'b0;
        end else begin
            check_done <= 1'b0;
            if (check_start) begin
                busy    <= 1'b1;
                pend    <= 1'b0;
                hit_acc <= 1'b0;
                idx     <= 2'd0;
            end else if (busy) begin
                if (bgnt) pend <= 1'b1;
                if (step) begin
                    pend    <= 1'b0;
                    hit_acc <= hit_acc | cell_hit;
                    idx     <= idx + 2'd1;
                    if (idx == 2'd3) begin
                        busy       <= 1'b0;
                        check_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (check_start) cl <= cells;
        if (step && idx == 2'd3) hit <= hit_acc | cell_hit;
    end

    a_no_overlap: assert property (@(posedge pclk) disable iff (rst)
        check_start |-> !busy);

endmodule

/* design/lock_unit.sv */
`timescale 1ns/100ps

module lock_unit import tetris_pkg::*; (
    input  logic         pclk,
    input  logic         rst,
    input  logic         lock_start,
    input  piece_cells_t cells,
    output logic         lock_done,
    output board_req_t   breq,
    input  logic         bgnt
);

    piece_cells_t cl;
    logic         busy;
    logic [1:0]   idx;
    cell_t        cur;

    assign cur  = cl[idx];
    assign breq = '{row: cur.row, col: cur.col, we: 1'b1, req: busy};

    always_ff @(posedge pclk) begin
        if (rst) begin
            busy      <= 1'b0;
            idx       <= 2'd0;
            lock_done <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                busy <= 1'b1;
                idx  <= 2'd0;
            end else if (busy && bgnt) begin
                idx <= idx + 2'd1;  // cell written on this edge
                if (idx == 2'd3) begin
                    busy      <= 1'b0;
                    lock_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (lock_start) cl <= cells;
    end

endmodule

/* design/piece_ctl.sv */
`timescale 1ns/100ps

module piece_ctl import tetris_pkg::*; #(
    parameter int fall_ticks = 50000
) (
    input  logic         pclk,
    input  logic         rst,
    input  logic         game_start,
    input  logic         btn_left,
    input  logic         btn_right,
    input  logic         btn_rot,
    input  logic         btn_drop,
    input  logic         check_done,
    input  logic         hit,
    input  logic         lock_done,
    output logic         check_start,
    output logic         lock_start,
    output piece_cells_t cells,
    output col_t         xpos,
    output row_t         ypos,
    output piece_e       block,
    output logic [1:0]   rot,
    output logic         piece_locked
);

    localparam int cnt_w = $clog2(fall_ticks);

    ctl_state_e       state;
    logic [cnt_w-1:0] fall_cnt;
    logic             move_left;  // latched direction for st_move
    shape_t           cur_shape;
    shape_t           move_shape;
    col_t             move_x;
    col_t             kick_x;
    int               lo;
    int               hi;
    piece_cells_t     cur_cells;
    piece_cells_t     cand_cells;

    assign move_x = move_left ? xpos - 4'd1 : xpos + 4'd1;

    always_comb begin
        cur_shape  = shape_cells(block, rot, xpos, ypos);
        move_shape = shape_cells(block, rot, move_x, ypos);
    end

    // absolute cells now and one row down
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            cur_cells[k].col  = xpos + col_t'(cur_shape.dc[k]);
            cur_cells[k].row  = ypos + row_t'(cur_shape.dr[k]);
            cand_cells[k].col = cur_cells[k].col;
            cand_cells[k].row = cur_cells[k].row + 5'd1;
        end
    end

    assign cells = (state == st_check) ? cand_cells : cur_cells;

    // wall kick, smallest shift into columns 0..9
    always_comb begin
        lo = int'(cur_shape.dc[0]);
        hi = lo;
        for (int k = 1; k < 4; k++) begin
            if (int'(cur_shape.dc[k]) < lo) lo = int'(cur_shape.dc[k]);
            if (int'(cur_shape.dc[k]) > hi) hi = int'(cur_shape.dc[k]);
        end
        kick_x = xpos;
        if (int'(xpos) + lo < 0) begin
            kick_x = col_t'(-lo);
        end else if (int'(xpos) + hi > board_cols - 1) begin
            kick_x = col_t'(board_cols - 1 - hi);
        end
    end

    // **********************************************************
    // control FSM
    // **********************************************************
    always_ff @(posedge pclk) begin
        if (rst) begin
            state       <= st_init;
            fall_cnt    <= '0;
            move_left   <= 1'b0;
            check_start <= 1'b0;
            lock_start  <= 1'b0;
            xpos        <= 4'd4;
            ypos        <= '0;
            block       <= i_piece;
            rot         <= 2'd0;
        end else begin
            check_start <= 1'b0;
            lock_start  <= 1'b0;
            case (state)
                st_init: begin
                    if (game_start) state <= st_idle;
                end
                st_idle: begin
                    if (btn_drop || fall_cnt == cnt_w'(fall_ticks - 1)) begin
                        fall_cnt    <= '0;
                        check_start <= 1'b1;
                        state       <= st_check;
                    end else begin
                        fall_cnt <= fall_cnt + 1'b1;
                        if (btn_left || btn_right) begin
                            move_left <= btn_left;  // left wins on a tie
                            state     <= st_move;
                        end else if (btn_rot) begin
                            state <= st_rot;
                        end
                    end
                end
                st_move: begin
                    if (move_shape.on_board) xpos <= move_x;
                    state <= st_idle;
                end
                st_rot: begin
                    rot   <= rot + 2'd1;
                    state <= st_kick;
                end
                st_kick: begin
                    xpos  <= kick_x;
                    state <= st_idle;
                end
                st_check: begin
                    if (check_done) begin
                        if (hit) begin
                            lock_start <= 1'b1;
                            state      <= st_lock;
                        end else begin
                            state <= st_down;
                        end
                    end
                end
                st_down: begin
                    ypos  <= ypos + 5'd1;
                    state <= st_idle;
                end
                st_lock: begin
                    if (lock_done) state <= st_spawn;
                end
                st_spawn: begin
                    block <= (block == l_piece) ? i_piece : piece_e'(block + 3'd1);
                    xpos  <= 4'd4;
                    ypos  <= '0;
                    rot   <= 2'd0;
                    state <= st_idle;
                end
                default: state <= st_init;
            endcase
        end
    end

    assign piece_locked = (state == st_spawn);

    a_start_excl: assert property (@(posedge pclk) disable iff (rst)
        !(check_start && lock_start));
    a_block_legal: assert property (@(posedge pclk) disable iff (rst)
        block inside {[i_piece:l_piece]});

endmodule

/* design/tetris_core.sv */
`timescale 1ns/100ps

module tetris_core import tetris_pkg::*; #(
    parameter int fall_ticks = 50000
) (
    input  logic       pclk,
    input  logic       rst,
    input  logic       game_start,
    input  logic       btn_left,
    input  logic       btn_right,
    input  logic       btn_rot,
    input  logic       btn_drop,
    input  logic       disp_req,
    input  row_t       disp_row,
    output logic       disp_valid,
    output row_bits_t  disp_bits,
    output col_t       xpos,
    output row_t       ypos,
    output piece_e     block,
    output logic [1:0] rot,
    output logic       piece_locked
);

    logic         check_start;
    logic         check_done;
    logic         hit;
    logic         lock_start;
    logic         lock_done;
    piece_cells_t cells;
    board_req_t   lock_breq;
    board_req_t   chk_breq;
    board_req_t   disp_breq;
    board_req_t   ram_req;
    logic         lock_gnt;
    logic         chk_gnt;
    logic         chk_rvalid;
    row_bits_t    rdata;

    assign disp_breq = '{row: disp_row, col: '0, we: 1'b0, req: disp_req};
    assign disp_bits = rdata;

    piece_ctl #(.fall_ticks(fall_ticks)) u_piece_ctl (
        .pclk, .rst, .game_start, .btn_left, .btn_right, .btn_rot, .btn_drop,
        .check_done, .hit, .lock_done, .check_start, .lock_start, .cells,
        .xpos, .ypos, .block, .rot, .piece_locked
    );

    collision_check u_collision_check (
        .pclk, .rst, .check_start, .cells, .check_done, .hit,
        .breq(chk_breq), .bgnt(chk_gnt), .rvalid(chk_rvalid), .rdata
    );

    lock_unit u_lock_unit (
        .pclk, .rst, .lock_start, .cells, .lock_done,
        .breq(lock_breq), .bgnt(lock_gnt)
    );

    board_arbiter u_board_arbiter (
        .lock_req(lock_breq), .chk_req(chk_breq), .disp_req(disp_breq),
        .lock_gnt, .chk_gnt, .disp_gnt(), .chk_rvalid, .disp_rvalid(disp_valid),
        .ram_req, .pclk, .rst
    );

    board_ram u_board_ram (.pclk, .rst, .ram_req, .rdata);

endmodule

/* design/tetris_pkg.sv */
package tetris_pkg;

    localparam int board_cols = 10;
    localparam int board_rows = 20;

    typedef logic [3:0] col_t;
    typedef logic [4:0] row_t;
    typedef logic [board_cols-1:0] row_bits_t;  // bit c set when column c filled
    typedef logic signed [2:0] delta_t;

    typedef enum logic [2:0] {
        i_piece, o_piece, t_piece, s_piece, z_piece, j_piece, l_piece
    } piece_e;

    typedef enum logic [3:0] {
        st_init, st_idle, st_move, st_rot, st_kick, st_check, st_down, st_lock, st_spawn
    } ctl_state_e;

    typedef struct packed {
        col_t col;
        row_t row;
    } cell_t;

    typedef cell_t [3:0] piece_cells_t;

    typedef struct packed {
        row_t row;
        col_t col;
        logic we;
        logic req;
    } board_req_t;

    typedef struct packed {
        delta_t [3:0] dc;
        delta_t [3:0] dr;
        logic         on_board;
    } shape_t;

    // **********************************************************
    // shape table, 4x4 box with anchor at box column 1, row 0
    // nibble per box row (row 3 leftmost), bit 0 is box column 0
    // **********************************************************
    function automatic shape_t shape_cells(piece_e kind, logic [1:0] rot,
                                           col_t acol, row_t arow);
        logic [15:0] box;
        int          n;
        int          c;
        int          r;
        shape_t      s;
        case ({kind, rot})
            {i_piece, 2'd0}: box = 16'b0000_0000_1111_0000;
            {i_piece, 2'd1}: box = 16'b0100_0100_0100_0100;
            {i_piece, 2'd2}: box = 16'b0000_1111_0000_0000;
            {i_piece, 2'd3}: box = 16'b0010_0010_0010_0010;
            {t_piece, 2'd0}: box = 16'b0000_0000_0111_0010;
            {t_piece, 2'd1}: box = 16'b0000_0010_0110_0010;
            {t_piece, 2'd2}: box = 16'b0000_0010_0111_0000;
            {t_piece, 2'd3}: box = 16'b0000_0010_0011_0010;
            {s_piece, 2'd0}: box = 16'b0000_0000_0011_0110;
            {s_piece, 2'd1}: box = 16'b0000_0100_0110_0010;
            {s_piece, 2'd2}: box = 16'b0000_0011_0110_0000;
            {s_piece, 2'd3}: box = 16'b0000_0010_0011_0001;
            {z_piece, 2'd0}: box = 16'b0000_0000_0110_0011;
            {z_piece, 2'd1}: box = 16'b0000_0010_0110_0100;
            {z_piece, 2'd2}: box = 16'b0000_0110_0011_0000;
            {z_piece, 2'd3}: box = 16'b0000_0001_0011_0010;
            {j_piece, 2'd0}: box = 16'b0000_0000_0111_0001;
            {j_piece, 2'd1}: box = 16'b0000_0010_0010_0110;
            {j_piece, 2'd2}: box = 16'b0000_0100_0111_0000;
            {j_piece, 2'd3}: box = 16'b0000_0011_0010_0010;
            {l_piece, 2'd0}: box = 16'b0000_0000_0111_0100;
            {l_piece, 2'd1}: box = 16'b0000_0110_0010_0010;
            {l_piece, 2'd2}: box = 16'b0000_0001_0111_0000;
            {l_piece, 2'd3}: box = 16'b0000_0010_0010_0011;
            default:         box = 16'b0000_0000_0110_0110;  // o piece, any rotation
        endcase
        s = '0;
        s.on_board = 1'b1;
        n = 0;
        for (int br = 0; br < 4; br++) begin
            for (int bc = 0; bc < 4; bc++) begin
                if (box[br*4+bc] && n < 4) begin
                    s.dc[n] = delta_t'(bc - 1);
                    s.dr[n] = delta_t'(br);
                    c = int'(acol) + bc - 1;
                    r = int'(arow) + br;
                    if (c < 0 || c >= board_cols || r >= board_rows) begin
                        s.on_board = 1'b0;
                    end
                    n++;
                end
            end
        end
        return s;
    endfunction

endpackage

/* dv/tetris_core_tb.sv */
`timescale 1ns/100ps

module tetris_core_tb;

    localparam int fall_ticks = 64;
    localparam int n_cols     = 10;
    localparam int n_rows     = 20;
    localparam int read_limit = 100;

    typedef enum logic [2:0] {
        a_start, a_left, a_right, a_rot, a_drop, a_wait_lock, a_read_row
    } action_e;

    typedef struct packed {
        action_e    act;
        logic [7:0] cnt;  // 0 means a random repeat count
    } step_t;

    logic       pclk;
    logic       rst;
    logic       game_start;
    logic       btn_left;
    logic       btn_right;
    logic       btn_rot;
    logic       btn_drop;
    logic       disp_req;
    logic [4:0] disp_row;
    logic       disp_valid;
    logic [9:0] disp_bits;
    logic [3:0] xpos;
    logic [4:0] ypos;
    logic [2:0] block;
    logic [1:0] rot;
    logic       piece_locked;

    // reference model
    logic [9:0] board [n_rows];
    logic [9:0] next_board [n_rows];  // board once the pending lock lands
    int         mx;
    int         my;
    int         mr;
    int         mb;
    int         pc [4];
    int         pr [4];
    bit         fall_done;
    step_t      steps [32];
    int         n_steps;

    tetris_core #(.fall_ticks(fall_ticks)) dut0 (
        .pclk(pclk), .rst(rst), .game_start(game_start),
        .btn_left(btn_left), .btn_right(btn_right), .btn_rot(btn_rot), .btn_drop(btn_drop),
        .disp_req(disp_req), .disp_row(disp_row), .disp_valid(disp_valid),
        .disp_bits(disp_bits), .xpos(xpos), .ypos(ypos), .block(block), .rot(rot),
        .piece_locked(piece_locked)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    // ************************************************************
    // shape table, one nibble per box row, rotation 3 leftmost
    // ************************************************************
    function automatic logic [15:0] shape_box(int kind, int r);
        logic [63:0] all;
        case (kind)
            0: all = 64'h2222_0f00_4444_00f0;
            1: all = 64'h0066_0066_0066_0066;
            2: all = 64'h0232_0270_0262_0072;
            3: all = 64'h0231_0360_0462_0036;
            4: all = 64'h0132_0630_0264_0063;
            5: all = 64'h0322_0470_0226_0071;
            default: all = 64'h0223_0170_0622_0074;  // l piece
        endcase
        return all[r*16 +: 16];
    endfunction

    // anchor sits on box column 1, top row
    function automatic void get_cells(int kind, int r, int x, int y);
        logic [15:0] box;
        int          n;
        box = shape_box(kind, r);
        n = 0;
        for (int b = 0; b < 16; b++) begin
            if (box[b]) begin
                pc[n] = x + (b % 4) - 1;
                pr[n] = y + b / 4;
                n++;
            end
        end
    endfunction

    function automatic bit fits_walls(int x);
        bit ok;
        get_cells(mb, mr, x, my);
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (pc[k] < 0 || pc[k] >= n_cols || pr[k] >= n_rows) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic int kicked_x();
        int lo;
        int hi;
        get_cells(mb, mr, mx, my);
        lo = pc[0];
        hi = pc[0];
        for (int k = 1; k < 4; k++) begin
            if (pc[k] < lo) lo = pc[k];
            if (pc[k] > hi) hi = pc[k];
        end
        if (lo < 0) return mx - lo;
        if (hi > n_cols - 1) return mx - (hi - (n_cols - 1));
        return mx;
    endfunction

    function automatic bit would_hit();
        bit h;
        get_cells(mb, mr, mx, my + 1);
        h = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (pr[k] >= n_rows) h = 1'b1;
            else if (board[pr[k]][pc[k]]) h = 1'b1;
        end
        return h;
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("error %s got %h exp %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_outputs();
        check_eq("xpos", int'(xpos), mx);
        check_eq("ypos", int'(ypos), my);
        check_eq("block", int'(block), mb);
        check_eq("rot", int'(rot), mr);
        check_eq("piece_locked", int'(piece_locked), 0);
    endtask

    task automatic add_step(input action_e a, input int c);
        steps[n_steps].act = a;
        steps[n_steps].cnt = 8'(c);
        n_steps++;
    endtask

    task automatic do_start();
        game_start = 1'b1;
        @(posedge pclk);
        #1;
        game_start = 1'b0;
        check_outputs();
    endtask

    task automatic do_move(input int dir);
        bit ok;
        ok = fits_walls(mx + dir);
        if (dir < 0) btn_left = 1'b1;
        else btn_right = 1'b1;
        @(posedge pclk);
        #1;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        check_eq("xpos", int'(xpos), mx);  // not yet on the first edge
        @(posedge pclk);
        #1;
        if (ok) mx = mx + dir;
        check_outputs();
    endtask

    task automatic do_rotate();
        btn_rot = 1'b1;
        @(posedge pclk);
        #1;
        btn_rot = 1'b0;
        repeat (2) begin
            @(posedge pclk);
            #1;
        end
        mr = (mr + 1) % 4;
        mx = kicked_x();
        check_outputs();
    endtask

    // one row down, or a lock and spawn when the piece is resting
    task automatic fall_step(input bit use_strobe, output bit locked);
        bit exp_hit;
        int limit;
        int n;
        exp_hit = would_hit();
        limit = use_strobe ? 64 : fall_ticks + 64;
        next_board = board;
        if (exp_hit) begin
            get_cells(mb, mr, mx, my);
            for (int k = 0; k < 4; k++) next_board[pr[k]][pc[k]] = 1'b1;
        end
        if (use_strobe) begin
            btn_drop = 1'b1;
            @(posedge pclk);
            #1;
            btn_drop = 1'b0;
        end
        n = 0;
        while (int'(ypos) == my && !piece_locked) begin
            if (n == limit) give_up("piece neither moved down nor locked");
            @(posedge pclk);
            #1;
            n++;
        end
        check_eq("piece_locked", int'(piece_locked), int'(exp_hit));
        locked = exp_hit;
        if (exp_hit) begin
            board = next_board;
            mb = (mb + 1) % 7;
            mx = 4;
            my = 0;
            mr = 0;
            @(posedge pclk);
            #1;
        end else begin
            my++;
        end
        check_outputs();
    endtask

    task automatic read_row(input int r, output logic [9:0] bits);
        int n;
        disp_row = 5'(r);
        disp_req = 1'b1;
        n = 0;
        @(posedge pclk);
        #1;
        while (!disp_valid) begin
            if (n == read_limit) give_up("display read never returned disp_valid");
            @(posedge pclk);
            #1;
            n++;
        end
        bits     = disp_bits;
        disp_req = 1'b0;
    endtask

    task automatic read_and_compare(input int r);
        logic [9:0] got;
        read_row(r, got);
        check_eq("disp_bits", int'(got), int'(board[r]));
    endtask

    // reads race the collision checker and the lock writes
    task automatic contend_reads();
        logic [9:0] got;
        int         r;
        r = n_rows - 1;
        while (!fall_done) begin
            read_row(r, got);
            assert (got == board[r] || got == next_board[r]) else begin
                $display("error disp_bits got %h exp %h", got, board[r]);
                $display("Checks failed");
                $fatal(1);
            end
            r = (r == n_rows - 5) ? n_rows - 1 : r - 1;
        end
    endtask

    task automatic fall_with_reads();
        bit locked;
        int guard;
        locked    = 1'b0;
        guard     = 0;
        fall_done = 1'b0;
        fork
            begin
                while (!locked) begin
                    if (guard == n_rows + 2) give_up("piece kept falling without a lock");
                    fall_step(1'b0, locked);
                    guard++;
                end
                fall_done = 1'b1;
            end
            contend_reads();
        join
    endtask

    initial begin
        int reps;
        rst        = 1'b1;
        game_start = 1'b0;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_rot    = 1'b0;
        btn_drop   = 1'b0;
        disp_req   = 1'b0;
        disp_row   = '0;
        void'($urandom(32'hbfbb9aab));
        for (int r = 0; r < n_rows; r++) begin
            board[r]      = '0;
            next_board[r] = '0;
        end
        mx = 4;
        my = 0;
        mr = 0;
        mb = 0;
        n_steps = 0;
        add_step(a_start, 1);
        add_step(a_left, 3);
        add_step(a_left, 2);       // against the left wall
        add_step(a_right, 0);
        add_step(a_rot, 1);
        add_step(a_right, 9);
        add_step(a_rot, 1);        // kick off the right wall
        add_step(a_rot, 1);
        add_step(a_left, 9);
        add_step(a_rot, 1);        // kick off the left wall
        add_step(a_drop, 0);
        add_step(a_wait_lock, 1);
        add_step(a_read_row, 19);
        add_step(a_read_row, 18);
        add_step(a_left, 4);
        add_step(a_wait_lock, 1);  // o lands on the i
        add_step(a_read_row, 17);
        add_step(a_read_row, 18);
        add_step(a_read_row, 19);
        add_step(a_right, 0);
        add_step(a_drop, 3);
        add_step(a_wait_lock, 1);
        add_step(a_read_row, 18);
        add_step(a_read_row, 19);

        repeat (10) @(posedge pclk);
        #1;
        rst = 1'b0;
        check_outputs();

        for (int i = 0; i < n_steps; i++) begin
            reps = (steps[i].cnt == 0) ? int'($urandom % 3) + 1 : int'(steps[i].cnt);
            case (steps[i].act)
                a_start:     do_start();
                a_left:      repeat (reps) do_move(-1);
                a_right:     repeat (reps) do_move(1);
                a_rot:       repeat (reps) do_rotate();
                a_drop: begin
                    repeat (reps) begin
                        bit unused_lock;
                        fall_step(1'b1, unused_lock);
                    end
                end
                a_wait_lock: fall_with_reads();
                default:     read_and_compare(reps);
            endcase
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
design/tetris_pkg.sv
design/board_ram.sv
design/board_arbiter.sv
design/lock_unit.sv
design/collision_check.sv
design/piece_ctl.sv
design/tetris_core.sv
dv/tetris_core_tb.sv
